// ==== source/cpuCtrl_cfg.svh ====
`ifndef CPU_CTRL_CFG_SVH
`define CPU_CTRL_CFG_SVH

// Widths
`define CPU_WORD_W        16
`define FLAG_W            4
`define FLAG_IDX_W        2
`define REG_SEL_W         3
`define ALU_FUNC_W        4
`define ALU_SEL_W         3
`define MEM_ADDR_SEL_W    2

// Opcode field positions
`define OPC_CLASS_MSB     15
`define OPC_CLASS_LSB     12
`define OPC_SRC_MSB       11  // Source 1, shared by all forms
`define OPC_SRC_LSB       9
`define OPC_A_FUNC_MSB    8
`define OPC_A_FUNC_LSB    5
`define OPC_A_BREG_MSB    4
`define OPC_A_BREG_LSB    3
`define OPC_A_DEST_MSB    2
`define OPC_A_DEST_LSB    0
`define OPC_I_FUNC_BIT    8   // Repeated twice in the I form
`define OPC_I_FUNC_MSB    13
`define OPC_I_FUNC_LSB    12
`define OPC_SI_FUNC_MSB   8
`define OPC_SI_FUNC_LSB   7
`define OPC_SI_DEST_MSB   6
`define OPC_SI_DEST_LSB   4
`define OPC_FLAG_SET_BIT  11  // FLS/FLC when set
`define OPC_FLAG_VAL_BIT  10
`define OPC_FLAG_IDX_MSB  9
`define OPC_FLAG_IDX_LSB  8

// Instruction classes, matched with casez
`define OPC_CLS_A         4'b0000
`define OPC_CLS_SI        4'b0001
`define OPC_CLS_FLAG      4'b0010
`define OPC_CLS_RESERVED  4'b0011  // Former stack group
`define OPC_CLS_I         4'b01??
`define OPC_CLS_J         4'b1???

// Destination codes
`define DEST_NONE         3'b000
`define DEST_A            3'b001
`define DEST_B            3'b010
`define DEST_C            3'b011
`define DEST_NOWRITE      3'b100
`define DEST_ABS          3'b101
`define DEST_ADDR_A       3'b110
`define DEST_ABS_IDX      3'b111

// Source modes, top bit clear means register
`define SRC_MEM_BIT       2
`define SRC_IMM           3'b100
`define SRC_ABS           3'b101
`define SRC_ADDR_A        3'b110
`define SRC_ABS_IDX       3'b111

// ALU operand A sources
`define ALUA_PC           3'd4
`define ALUA_MEM          3'd5
`define ALUA_HIMEM        3'd6

// ALU operand B sources
`define ALUB_ZERO         3'd0
`define ALUB_A            3'd1
`define ALUB_ONE          3'd4
`define ALUB_OPERAND      3'd5
`define ALUB_JUMP_ADDR    3'd6

// Memory address sources
`define MADDR_PC          2'd0
`define MADDR_A           2'd1
`define MADDR_ALU         2'd2

// Memory write data and flag input sources
`define WDS_ALU           1'b0
`define WDS_RESULT        1'b1
`define FLAG_SRC_INF      1'b1

// ALU functions
`define ALU_ADD           4'b0000
`define ALU_JUMP_SIGN     4'b0110
`define ALU_SI_PREFIX     2'b10

`endif

// ==== source/cpuCtrlPkg.sv ====
`default_nettype none

`include "cpuCtrl_cfg.svh"

package cpuCtrlPkg;

    typedef logic [`CPU_WORD_W-1:0]     instrWord_t;
    typedef logic [`FLAG_W-1:0]         flagVec_t;
    typedef logic [`REG_SEL_W-1:0]      regSel_t;   // Destination or source mode
    typedef logic [`ALU_FUNC_W-1:0]     aluFunc_t;
    typedef logic [`ALU_SEL_W-1:0]      aluASel_t;
    typedef logic [`ALU_SEL_W-1:0]      aluBSel_t;
    typedef logic [`MEM_ADDR_SEL_W-1:0] memAddrSel_t;

    typedef enum logic [2:0] {
        clsAlu,
        clsJump,
        clsFlagJump,
        clsFlagSet,
        clsSkip,      // Flag jump with a false condition
        clsInvalid
    } instrClass_t;

    typedef enum logic [4:0] {
        stIdle, stFetch, stExec, stJump, stFlagJump,
        stReadImm, stReadAddr,
        stReadAbsLo, stReadAbsHi, stReadAbsFinal,
        stReadAbsIdxLo, stReadAbsIdxHi, stReadAbsIdxFinal,
        stWriteAbsLo, stWriteAbsHi, stWriteAbsFinal,
        stWriteAbsIdxLo, stWriteAbsIdxHi, stWriteAbsIdxFinal,
        stHalt
    } ctrlState_t;

    typedef struct packed {
        instrClass_t                instrClass;
        regSel_t                    srcMode;
        regSel_t                    dest;
        aluFunc_t                   aluFunc;
        aluBSel_t                   aluBSel;   // B source used in exec
        logic [`FLAG_IDX_W-1:0]     flagIdx;
        logic                       flagVal;
    } decodedInstr_t;

    typedef struct packed {
        memAddrSel_t memAddr;
        logic        enPC;
        logic        saveOpcode;
        logic        saveMem1;
        logic        saveMem2;
        aluFunc_t    aluFunc;
        aluASel_t    aluA;
        aluBSel_t    aluB;
        logic        enA;
        logic        enB;
        logic        enC;
        logic        we;
        logic        re;
        logic        writeDataSource;
        logic        saveResult;
        logic        enF;
        logic        sourceF;
        flagVec_t    inF;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`default_nettype none

`include "cpuCtrl_cfg.svh"

module instrDecoder (
    input  wire cpuCtrlPkg::instrWord_t opcode,
    input  wire cpuCtrlPkg::flagVec_t   flags,
    output cpuCtrlPkg::decodedInstr_t   decoded
);

    logic [`OPC_CLASS_MSB:`OPC_CLASS_LSB]    opClass;
    cpuCtrlPkg::regSel_t                     srcField;
    logic [`FLAG_IDX_W-1:0]                  flagIdx;
    logic                                    flagVal;
    logic                                    flagHit;

    assign opClass  = opcode[`OPC_CLASS_MSB:`OPC_CLASS_LSB];
    assign srcField = opcode[`OPC_SRC_MSB:`OPC_SRC_LSB];
    assign flagIdx  = opcode[`OPC_FLAG_IDX_MSB:`OPC_FLAG_IDX_LSB];
    assign flagVal  = opcode[`OPC_FLAG_VAL_BIT];

    // JFS/JFC condition
    assign flagHit = (flags[flagIdx] == flagVal);

    always_comb begin
        decoded            = '0;
        decoded.instrClass = cpuCtrlPkg::clsInvalid;
        decoded.srcMode    = srcField;
        decoded.dest       = `DEST_NONE;
        decoded.aluBSel    = `ALUB_OPERAND;   // I and SI forms use the operand
        decoded.flagIdx    = flagIdx;
        decoded.flagVal    = flagVal;

        casez (opClass)
            `OPC_CLS_A: begin
                decoded.instrClass = cpuCtrlPkg::clsAlu;
                decoded.dest       = opcode[`OPC_A_DEST_MSB:`OPC_A_DEST_LSB];
                decoded.aluFunc    = opcode[`OPC_A_FUNC_MSB:`OPC_A_FUNC_LSB];
                decoded.aluBSel    = {1'b0, opcode[`OPC_A_BREG_MSB:`OPC_A_BREG_LSB]};
            end
            `OPC_CLS_I: begin
                // Source field doubles as destination
                decoded.instrClass = cpuCtrlPkg::clsAlu;
                decoded.dest       = srcField;
                decoded.aluFunc    = {opcode[`OPC_I_FUNC_BIT], opcode[`OPC_I_FUNC_BIT],
                                      opcode[`OPC_I_FUNC_MSB:`OPC_I_FUNC_LSB]};
            end
            `OPC_CLS_SI: begin
                decoded.instrClass = cpuCtrlPkg::clsAlu;
                decoded.dest       = opcode[`OPC_SI_DEST_MSB:`OPC_SI_DEST_LSB];
                decoded.aluFunc    = {`ALU_SI_PREFIX,
                                      opcode[`OPC_SI_FUNC_MSB:`OPC_SI_FUNC_LSB]};
            end
            `OPC_CLS_J: begin
                decoded.instrClass = cpuCtrlPkg::clsJump;
            end
            `OPC_CLS_FLAG: begin
                if (opcode[`OPC_FLAG_SET_BIT]) begin
                    decoded.instrClass = cpuCtrlPkg::clsFlagSet;  // FLS/FLC
                end else if (flagHit) begin
                    decoded.instrClass = cpuCtrlPkg::clsFlagJump;
                end else begin
                    decoded.instrClass = cpuCtrlPkg::clsSkip;     // Condition false
                end
            end
            `OPC_CLS_RESERVED: begin
                decoded.instrClass = cpuCtrlPkg::clsInvalid;      // No stack group
            end
            default: begin
                decoded.instrClass = cpuCtrlPkg::clsInvalid;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ctrlSequencer.sv ====
`default_nettype none

`include "cpuCtrl_cfg.svh"

module ctrlSequencer (
    input  wire                             clk,
    input  wire                             rst,
    input  wire cpuCtrlPkg::decodedInstr_t  decoded,
    output cpuCtrlPkg::ctrlState_t          state
);

    cpuCtrlPkg::ctrlState_t nextState;
    cpuCtrlPkg::ctrlState_t readEntry;   // First state of the source read chain

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpuCtrlPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (decoded.srcMode)
            `SRC_IMM:     readEntry = cpuCtrlPkg::stReadImm;
            `SRC_ADDR_A:  readEntry = cpuCtrlPkg::stReadAddr;
            `SRC_ABS:     readEntry = cpuCtrlPkg::stReadAbsLo;
            `SRC_ABS_IDX: readEntry = cpuCtrlPkg::stReadAbsIdxLo;
            default:      readEntry = cpuCtrlPkg::stExec;   // Register operand
        endcase
    end

    always_comb begin
        nextState = cpuCtrlPkg::stHalt;
        case (state)
            cpuCtrlPkg::stIdle: nextState = cpuCtrlPkg::stFetch;

            cpuCtrlPkg::stFetch: begin
                case (decoded.instrClass)
                    cpuCtrlPkg::clsAlu:      nextState = readEntry;
                    cpuCtrlPkg::clsJump:     nextState = cpuCtrlPkg::stJump;
                    cpuCtrlPkg::clsFlagJump: nextState = cpuCtrlPkg::stFlagJump;
                    cpuCtrlPkg::clsFlagSet,
                    cpuCtrlPkg::clsSkip:     nextState = cpuCtrlPkg::stFetch;
                    default:                 nextState = cpuCtrlPkg::stHalt;
                endcase
            end

            // Read chains end in exec
            cpuCtrlPkg::stReadImm,
            cpuCtrlPkg::stReadAddr,
            cpuCtrlPkg::stReadAbsFinal,
            cpuCtrlPkg::stReadAbsIdxFinal: nextState = cpuCtrlPkg::stExec;

            cpuCtrlPkg::stReadAbsLo:    nextState = cpuCtrlPkg::stReadAbsHi;
            cpuCtrlPkg::stReadAbsHi:    nextState = cpuCtrlPkg::stReadAbsFinal;
            cpuCtrlPkg::stReadAbsIdxLo: nextState = cpuCtrlPkg::stReadAbsIdxHi;
            cpuCtrlPkg::stReadAbsIdxHi: nextState = cpuCtrlPkg::stReadAbsIdxFinal;

            cpuCtrlPkg::stExec: begin
                if (decoded.dest == `DEST_ABS) begin
                    nextState = cpuCtrlPkg::stWriteAbsLo;
                end else if (decoded.dest == `DEST_ABS_IDX) begin
                    nextState = cpuCtrlPkg::stWriteAbsIdxLo;
                end else begin
                    nextState = cpuCtrlPkg::stFetch;
                end
            end

            cpuCtrlPkg::stWriteAbsLo:    nextState = cpuCtrlPkg::stWriteAbsHi;
            cpuCtrlPkg::stWriteAbsHi:    nextState = cpuCtrlPkg::stWriteAbsFinal;
            cpuCtrlPkg::stWriteAbsIdxLo: nextState = cpuCtrlPkg::stWriteAbsIdxHi;
            cpuCtrlPkg::stWriteAbsIdxHi: nextState = cpuCtrlPkg::stWriteAbsIdxFinal;

            // Single-cycle tails back to fetch
            cpuCtrlPkg::stJump,
            cpuCtrlPkg::stFlagJump,
            cpuCtrlPkg::stWriteAbsFinal,
            cpuCtrlPkg::stWriteAbsIdxFinal: nextState = cpuCtrlPkg::stFetch;

            cpuCtrlPkg::stHalt: nextState = cpuCtrlPkg::stHalt;  // Wait for reset

            default: nextState = cpuCtrlPkg::stHalt;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ctrlWordGen.sv ====
`default_nettype none

`include "cpuCtrl_cfg.svh"

module ctrlWordGen (
    input  wire cpuCtrlPkg::ctrlState_t     state,
    input  wire cpuCtrlPkg::decodedInstr_t  decoded,
    input  wire cpuCtrlPkg::flagVec_t       flags,
    output cpuCtrlPkg::ctrlWord_t           ctrl
);

    cpuCtrlPkg::flagVec_t flagMask;
    cpuCtrlPkg::flagVec_t flagsUpdated;  // Result of FLS/FLC

    assign flagMask     = cpuCtrlPkg::flagVec_t'(1) << decoded.flagIdx;
    assign flagsUpdated = decoded.flagVal ? (flags | flagMask) : (flags & ~flagMask);

    // Read the word at PC and step PC by one
    function automatic cpuCtrlPkg::ctrlWord_t readAtPc(input cpuCtrlPkg::ctrlWord_t w);
        w.memAddr = `MADDR_PC;
        w.re      = 1'b1;
        w.aluFunc = `ALU_ADD;
        w.aluA    = `ALUA_PC;
        w.aluB    = `ALUB_ONE;
        w.enPC    = 1'b1;
        return w;
    endfunction

    // Address from the high memory value, optionally indexed by A
    function automatic cpuCtrlPkg::ctrlWord_t absAddress(input cpuCtrlPkg::ctrlWord_t w,
                                                         input logic indexed);
        w.memAddr = `MADDR_ALU;
        w.aluFunc = `ALU_ADD;
        w.aluA    = `ALUA_HIMEM;
        w.aluB    = indexed ? `ALUB_A : `ALUB_ZERO;
        return w;
    endfunction

    always_comb begin
        ctrl = '0;
        case (state)
            cpuCtrlPkg::stFetch: begin
                ctrl            = readAtPc(ctrl);
                ctrl.saveOpcode = 1'b1;
                if (decoded.instrClass == cpuCtrlPkg::clsFlagSet) begin
                    ctrl.enF     = 1'b1;
                    ctrl.sourceF = `FLAG_SRC_INF;
                    ctrl.inF     = flagsUpdated;
                end
            end

            cpuCtrlPkg::stExec: begin
                if (decoded.srcMode[`SRC_MEM_BIT]) begin
                    ctrl.aluA = `ALUA_MEM;                      // Operand fetched earlier
                end else begin
                    ctrl.aluA = {1'b0, decoded.srcMode[1:0]};  // Register codes line up
                end
                ctrl.aluFunc = decoded.aluFunc;
                ctrl.aluB    = decoded.aluBSel;
                ctrl.enF     = 1'b1;
                case (decoded.dest)
                    `DEST_A: ctrl.enA = 1'b1;
                    `DEST_B: ctrl.enB = 1'b1;
                    `DEST_C: ctrl.enC = 1'b1;
                    `DEST_ADDR_A: begin
                        ctrl.we              = 1'b1;
                        ctrl.writeDataSource = `WDS_ALU;
                        ctrl.memAddr         = `MADDR_A;
                    end
                    `DEST_ABS,
                    `DEST_ABS_IDX: ctrl.saveResult = 1'b1;    // Written by the write chain
                    `DEST_NONE,
                    `DEST_NOWRITE: ;                          // Flags only
                endcase
            end

            cpuCtrlPkg::stJump: begin
                ctrl.aluFunc = `ALU_JUMP_SIGN;
                ctrl.aluA    = `ALUA_PC;
                ctrl.aluB    = `ALUB_JUMP_ADDR;
                ctrl.enPC    = 1'b1;
            end

            cpuCtrlPkg::stFlagJump: begin
                ctrl.aluFunc = `ALU_ADD;
                ctrl.aluA    = `ALUA_PC;
                ctrl.aluB    = `ALUB_OPERAND;  // Relative offset
                ctrl.enPC    = 1'b1;
            end

            cpuCtrlPkg::stReadImm: begin
                ctrl          = readAtPc(ctrl);
                ctrl.saveMem1 = 1'b1;
            end

            cpuCtrlPkg::stReadAddr: begin
                ctrl.memAddr  = `MADDR_A;
                ctrl.re       = 1'b1;
                ctrl.saveMem1 = 1'b1;
            end

            // Low address word
            cpuCtrlPkg::stReadAbsLo,
            cpuCtrlPkg::stReadAbsIdxLo,
            cpuCtrlPkg::stWriteAbsLo,
            cpuCtrlPkg::stWriteAbsIdxLo: begin
                ctrl          = readAtPc(ctrl);
                ctrl.saveMem2 = 1'b1;
            end

            // High address word
            cpuCtrlPkg::stReadAbsHi,
            cpuCtrlPkg::stReadAbsIdxHi,
            cpuCtrlPkg::stWriteAbsHi,
            cpuCtrlPkg::stWriteAbsIdxHi: begin
                ctrl          = readAtPc(ctrl);
                ctrl.saveMem1 = 1'b1;
            end

            cpuCtrlPkg::stReadAbsFinal,
            cpuCtrlPkg::stReadAbsIdxFinal: begin
                ctrl          = absAddress(ctrl, state == cpuCtrlPkg::stReadAbsIdxFinal);
                ctrl.re       = 1'b1;
                ctrl.saveMem1 = 1'b1;
            end

            cpuCtrlPkg::stWriteAbsFinal,
            cpuCtrlPkg::stWriteAbsIdxFinal: begin
                ctrl                 = absAddress(ctrl,
                                                  state == cpuCtrlPkg::stWriteAbsIdxFinal);
                ctrl.we              = 1'b1;
                ctrl.writeDataSource = `WDS_RESULT;
            end

            default: ;  // Idle and halt stay quiet
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpuController.sv ====
`default_nettype none

module cpuController (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cpuCtrlPkg::instrWord_t opcode,
    input  wire cpuCtrlPkg::flagVec_t   flags,
    output cpuCtrlPkg::ctrlWord_t       ctrl
);

    cpuCtrlPkg::decodedInstr_t decoded;
    cpuCtrlPkg::ctrlState_t    state;

    instrDecoder i_decoder (
        .opcode  (opcode),
        .flags   (flags),
        .decoded (decoded)
    );

    // Only storage in the controller
    ctrlSequencer i_sequencer (
        .clk     (clk),
        .rst     (rst),
        .decoded (decoded),
        .state   (state)
    );

    ctrlWordGen i_wordGen (
        .state   (state),
        .decoded (decoded),
        .flags   (flags),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

// ==== verification/cpuController_asserts.sv ====
`default_nettype none

module cpuController_asserts (
    input wire                          clk,
    input wire                          rst,
    input wire cpuCtrlPkg::ctrlState_t  state,
    input wire cpuCtrlPkg::ctrlWord_t   ctrl
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;  // Read by the testbench when the run ends

    noReadWithWrite: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.we && ctrl.re))
    else begin
        $error("we and re set in the same cycle");
        failCount++;
    end

    oneRegEnable: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.enA, ctrl.enB, ctrl.enC}))
    else begin
        $error("more than one register enable set");
        failCount++;
    end

    // Low address word is always followed by the high word
    mem2ThenMem1: assert property (@(posedge clk) disable iff (rst)
        ctrl.saveMem2 |=> ctrl.saveMem1)
    else begin
        $error("saveMem2 not followed by saveMem1");
        failCount++;
    end

    quietStates: assert property (@(posedge clk)
        (state == cpuCtrlPkg::stIdle || state == cpuCtrlPkg::stHalt) |-> ctrl == '0)
    else begin
        $error("control word not zero in idle or halt");
        failCount++;
    end

endmodule

bind cpuController cpuController_asserts i_checks (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .ctrl  (ctrl)
);

`default_nettype wire

// ==== verification/tbCpuController.sv ====
`default_nettype none

module tbCpuController;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk = 1'b0;
    logic                   rst;
    cpuCtrlPkg::instrWord_t opcode;
    cpuCtrlPkg::flagVec_t   flags;
    cpuCtrlPkg::ctrlWord_t  ctrl;
    cpuCtrlPkg::ctrlWord_t  trace [0:19];  // One control word per cycle of an instruction
    int                     traceLen;
    int                     reCount;
    int                     weCount;
    string                  testName;
    int                     testCount = 0;
    int                     checkCount = 0;
    int                     errorCount = 0;
    int                     testErrStart;
    int                     iter;
    integer                 seed;
    logic [31:0]            rnd;
    cpuCtrlPkg::flagVec_t   expFlags;

    cpuController i_dut (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    always #20 clk = ~clk;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        assert (exp === act) else begin
            $display("error %s %s: expected %0h, actual %0h", testName, what, exp, act);
            errorCount++;
        end
    endtask

    task automatic startTest(input string name);
        testName     = name;
        testErrStart = errorCount;
    endtask

    task automatic finishTest();
        testCount++;
        $display("test %s %s", testName, (errorCount == testErrStart) ? "ok" : "had errors");
    endtask

    // Sits at 2 ns after a rising edge until the cycle is a fetch
    task automatic waitFetch();
        int n;
        n = 0;
        while (!ctrl.saveOpcode && n < 20) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ctrl.saveOpcode) begin
            $display("timeout in %s: the controller never reached a fetch cycle", testName);
            errorCount++;
        end
    endtask

    // Issues one instruction at fetch and records its cycles up to the next fetch
    task automatic runInstr(input cpuCtrlPkg::instrWord_t opc, input cpuCtrlPkg::flagVec_t flg);
        waitFetch();
        opcode   = opc;
        flags    = flg;
        traceLen = 0;
        reCount  = 0;
        weCount  = 0;
        do begin
            @(negedge clk);
            trace[traceLen] = ctrl;
            reCount += ctrl.re;
            weCount += ctrl.we;
            traceLen++;
            @(posedge clk);
            #2;
        end while (!ctrl.saveOpcode && traceLen < 20);
        if (!ctrl.saveOpcode) begin
            $display("timeout in %s: the instruction never returned to fetch", testName);
            errorCount++;
        end
    endtask

    task automatic checkShape(input int cycles, input int reads, input int writes);
        check("cycles", cycles, traceLen);
        check("reads", reads, reCount);
        check("writes", writes, weCount);
    endtask

    initial begin
        seed   = 32'hf6ed0c59;
        rst    = 1'b1;
        opcode = '0;
        flags  = '0;

        startTest("reset");
        repeat (4) begin
            @(negedge clk);
            check("ctrl in reset", '0, ctrl);
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check("ctrl in idle", '0, ctrl);
        @(negedge clk);
        check("fetch fields", {3'b111, 3'd4, 3'd4},  // PC plus one
              {ctrl.re, ctrl.saveOpcode, ctrl.enPC, ctrl.aluA, ctrl.aluB});
        @(posedge clk);
        #2;
        finishTest();

        startTest("aTypeReg");
        for (iter = 1; iter <= 3; iter++) begin
            rnd = $random(seed);
            runInstr({4'b0000, 1'b0, rnd[1:0], rnd[5:2], rnd[7:6], iter[2:0]}, flags);
            checkShape(2, 1, 0);
            check("exec func", rnd[5:2], trace[1].aluFunc);
            check("exec aluA", rnd[1:0], trace[1].aluA);
            check("exec aluB", rnd[7:6], trace[1].aluB);
            check("exec enF", 1, trace[1].enF);
            check("dest enables", 3'b100 >> (iter - 1),
                  {trace[1].enA, trace[1].enB, trace[1].enC});
        end
        finishTest();

        startTest("iTypeImm");
        rnd = $random(seed);
        runInstr({2'b01, rnd[1:0], 3'b100, rnd[2], rnd[10:3]}, flags);
        checkShape(3, 2, 0);
        check("readImm strobes", 2'b11, {trace[1].saveMem1, trace[1].enPC});
        check("exec sources", {3'd5, 3'd5}, {trace[2].aluA, trace[2].aluB});
        check("exec func", {rnd[2], rnd[2], rnd[1:0]}, trace[2].aluFunc);
        finishTest();

        startTest("siTypeAbs");
        rnd = $random(seed);
        runInstr({4'b0001, 3'b111, rnd[1:0], 3'b101, rnd[5:2]}, flags);
        checkShape(8, 6, 1);
        check("address words", 4'b1111,
              {trace[1].saveMem2, trace[2].saveMem1, trace[5].saveMem2, trace[6].saveMem1});
        check("indexed aluB", 1, trace[3].aluB);
        check("final addresses", {2'd2, 2'd2}, {trace[3].memAddr, trace[7].memAddr});  // ALU
        check("exec func", {2'b10, rnd[1:0]}, trace[4].aluFunc);
        check("exec saveResult", 1, trace[4].saveResult);
        check("final write", {2'b11, 3'd0},
              {trace[7].we, trace[7].writeDataSource, trace[7].aluB});
        finishTest();

        startTest("flags");
        for (iter = 0; iter < 6; iter++) begin
            rnd                = $random(seed);
            expFlags           = rnd[3:0];
            expFlags[rnd[5:4]] = rnd[6];  // Set for FLS, clear for FLC
            runInstr({4'b0010, 1'b1, rnd[6], rnd[5:4], 8'h00}, rnd[3:0]);
            checkShape(1, 1, 0);
            check("flag update", {2'b11, expFlags},
                  {trace[0].enF, trace[0].sourceF, trace[0].inF});
            runInstr({4'b0010, 1'b0, rnd[6], rnd[5:4], rnd[15:8]}, rnd[3:0]);
            if (flags[rnd[5:4]] == rnd[6]) begin
                checkShape(2, 1, 0);
                check("taken enPC", 1, trace[1].enPC);
            end else begin
                checkShape(1, 1, 0);
            end
        end
        finishTest();

        startTest("jump");
        rnd = $random(seed);
        runInstr({1'b1, rnd[14:0]}, flags);
        checkShape(2, 1, 0);
        check("jump fields", {4'b0110, 1'b1}, {trace[1].aluFunc, trace[1].enPC});
        finishTest();

        startTest("invalid");
        waitFetch();
        opcode = {4'b0011, rnd[26:15]};
        @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            check("halted ctrl", '0, ctrl);
        end
        @(posedge clk);
        #2;
        rst = 1'b1;
        @(posedge clk);
        #2;
        rst    = 1'b0;
        opcode = '0;
        waitFetch();  // Back to fetch after reset
        finishTest();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testCount, checkCount, errorCount, i_dut.i_checks.failCount);
        if (errorCount == 0 && i_dut.i_checks.failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/cpuCtrlPkg.sv
source/instrDecoder.sv
source/ctrlSequencer.sv
source/ctrlWordGen.sv
source/cpuController.sv
verification/cpuController_asserts.sv
verification/tbCpuController.sv

// ==== Bender.yml ====
package:
  name: cpu_controller

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cpuCtrlPkg.sv
      - source/instrDecoder.sv
      - source/ctrlSequencer.sv
      - source/ctrlWordGen.sv
      - source/cpuController.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/cpuController_asserts.sv
      - verification/tbCpuController.sv
